// ==== logic/standby_settings.svh ====
// Standby target settings: data widths and register reset defaults
`ifndef STANDBY_SETTINGS_SVH
`define STANDBY_SETTINGS_SVH

`define STBY_TIMER_W 20
`define STBY_WORD_W 32

`define STBY_STATIC_ADDR_RST 7'h22
// Dynamic address starts out not valid
`define STBY_DYN_ADDR_RST 7'h5A

`define STBY_T_FREE_RST 20'd40
`define STBY_T_IDLE_RST 20'd80
`define STBY_T_AVAIL_RST 20'd160

`endif

// ==== logic/standby_pkg.sv ====
// Standby target types: engine states, register selector and shared buses
`include "standby_settings.svh"

package standby_pkg;

  typedef enum logic [2:0] {
    IDLE,
    ADDR,
    ADDR_ACK,
    RX_BYTE,
    RX_ACK,
    TX_BYTE,
    TX_ACK
  } target_state_e;

  typedef enum logic [2:0] {
    REG_CTRL    = 3'd0,
    REG_ADDR    = 3'd1,
    REG_T_FREE  = 3'd2,
    REG_T_IDLE  = 3'd3,
    REG_T_AVAIL = 3'd4,
    REG_STATUS  = 3'd5
  } reg_addr_e;

  typedef struct packed {
    logic                     enable;
    logic [6:0]               static_addr;
    logic [6:0]               dyn_addr;
    logic                     dyn_addr_valid;
    logic [`STBY_TIMER_W-1:0] t_bus_free;
    logic [`STBY_TIMER_W-1:0] t_bus_idle;
    logic [`STBY_TIMER_W-1:0] t_bus_available;
  } standby_cfg_t;

  typedef struct packed {
    logic start;
    logic stop;
    logic scl_rise;
    logic scl_fall;
    logic sda;
  } bus_cond_t;

  typedef struct packed {
    logic busy;
    logic free;
    logic idle;
    logic available;
  } bus_state_t;

  typedef struct packed {
    logic cmd_complete;
    logic nack;
    logic read_cmd;
    logic rx_overflow;
  } target_evt_t;

endpackage

// ==== logic/bus_monitor.sv ====
// Bus monitor: synchronizes SCL and SDA and flags START, STOP and SCL edges
`timescale 1ns/1ns

module bus_monitor (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   enable_i,
  input  logic                   scl_i,
  input  logic                   sda_i,
  output standby_pkg::bus_cond_t cond_o
);

  logic [1:0] scl_sync_q;
  logic [1:0] sda_sync_q;
  logic       scl_prev_q;
  logic       sda_prev_q;
  logic       scl_s;
  logic       sda_s;

  assign scl_s = scl_sync_q[1];
  assign sda_s = sda_sync_q[1];

  // Lines rest high, so no edge is seen out of reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      scl_sync_q <= 2'b11;
      sda_sync_q <= 2'b11;
      scl_prev_q <= 1'b1;
      sda_prev_q <= 1'b1;
      cond_o     <= '{start: 1'b0, stop: 1'b0, scl_rise: 1'b0, scl_fall: 1'b0, sda: 1'b1};
    end else begin
      scl_sync_q <= {scl_sync_q[0], scl_i};
      sda_sync_q <= {sda_sync_q[0], sda_i};
      scl_prev_q <= scl_s;
      sda_prev_q <= sda_s;
      // SDA moving while SCL stays high
      cond_o.start    <= enable_i && scl_s && scl_prev_q && sda_prev_q && !sda_s;
      cond_o.stop     <= enable_i && scl_s && scl_prev_q && !sda_prev_q && sda_s;
      cond_o.scl_rise <= enable_i && scl_s && !scl_prev_q;
      cond_o.scl_fall <= enable_i && !scl_s && scl_prev_q;
      cond_o.sda      <= sda_s;
    end
  end

  a_start_stop_exclusive: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) !(cond_o.start && cond_o.stop)
  ) else $error("bus_monitor: START and STOP flagged together");

endmodule

// ==== logic/bus_timers.sv ====
// Bus timers: count quiet cycles after STOP and raise free, idle and available
`timescale 1ns/1ns
`include "standby_settings.svh"

module bus_timers (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  standby_pkg::standby_cfg_t cfg_i,
  input  standby_pkg::bus_cond_t    cond_i,
  output standby_pkg::bus_state_t   state_o
);

  logic [`STBY_TIMER_W-1:0] cnt_q;
  logic                     busy_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      busy_q <= 1'b0;
    end else if (cond_i.stop) begin
      cnt_q  <= '0;
      busy_q <= 1'b0;
    end else if (cond_i.start) begin
      busy_q <= 1'b1;
    end else if (!busy_q && (cnt_q != '1)) begin
      // Saturates at the top
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign state_o.busy      = busy_q;
  assign state_o.free      = !busy_q && (cnt_q >= cfg_i.t_bus_free);
  assign state_o.idle      = !busy_q && (cnt_q >= cfg_i.t_bus_idle);
  assign state_o.available = !busy_q && (cnt_q >= cfg_i.t_bus_available);

  // Holds while the limits are set free <= idle <= available
  a_level_order: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (state_o.available -> state_o.idle) && (state_o.idle -> state_o.free)
  ) else $error("bus_timers: bus levels out of order");

endmodule

// ==== logic/standby_regs.sv ====
// Standby registers: enable, addresses, bus timer limits and status read-back
`timescale 1ns/1ns
`include "standby_settings.svh"

module standby_regs (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      reg_we_i,
  input  standby_pkg::reg_addr_e    reg_addr_i,
  input  logic [`STBY_WORD_W-1:0]   reg_wdata_i,
  output logic [`STBY_WORD_W-1:0]   reg_rdata_o,
  input  standby_pkg::bus_state_t   bus_state_i,
  output standby_pkg::standby_cfg_t cfg_o
);

  standby_pkg::standby_cfg_t cfg_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_q.enable          <= 1'b0;
      cfg_q.static_addr     <= `STBY_STATIC_ADDR_RST;
      cfg_q.dyn_addr        <= `STBY_DYN_ADDR_RST;
      cfg_q.dyn_addr_valid  <= 1'b0;
      cfg_q.t_bus_free      <= `STBY_T_FREE_RST;
      cfg_q.t_bus_idle      <= `STBY_T_IDLE_RST;
      cfg_q.t_bus_available <= `STBY_T_AVAIL_RST;
    end else if (reg_we_i) begin
      case (reg_addr_i)
        standby_pkg::REG_CTRL: cfg_q.enable <= reg_wdata_i[0];
        standby_pkg::REG_ADDR: begin
          cfg_q.static_addr    <= reg_wdata_i[6:0];
          cfg_q.dyn_addr       <= reg_wdata_i[14:8];
          cfg_q.dyn_addr_valid <= reg_wdata_i[15];
        end
        standby_pkg::REG_T_FREE:  cfg_q.t_bus_free      <= reg_wdata_i[`STBY_TIMER_W-1:0];
        standby_pkg::REG_T_IDLE:  cfg_q.t_bus_idle      <= reg_wdata_i[`STBY_TIMER_W-1:0];
        standby_pkg::REG_T_AVAIL: cfg_q.t_bus_available <= reg_wdata_i[`STBY_TIMER_W-1:0];
        // STATUS is read only
        default: ;
      endcase
    end
  end

  always_comb begin
    reg_rdata_o = '0;
    case (reg_addr_i)
      standby_pkg::REG_CTRL: reg_rdata_o[0] = cfg_q.enable;
      standby_pkg::REG_ADDR: begin
        reg_rdata_o[6:0]  = cfg_q.static_addr;
        reg_rdata_o[14:8] = cfg_q.dyn_addr;
        reg_rdata_o[15]   = cfg_q.dyn_addr_valid;
      end
      standby_pkg::REG_T_FREE:  reg_rdata_o[`STBY_TIMER_W-1:0] = cfg_q.t_bus_free;
      standby_pkg::REG_T_IDLE:  reg_rdata_o[`STBY_TIMER_W-1:0] = cfg_q.t_bus_idle;
      standby_pkg::REG_T_AVAIL: reg_rdata_o[`STBY_TIMER_W-1:0] = cfg_q.t_bus_available;
      // busy, free, idle, available from bit 3 down
      standby_pkg::REG_STATUS:  reg_rdata_o[3:0] = bus_state_i;
      default: ;
    endcase
  end

  assign cfg_o = cfg_q;

endmodule

// ==== logic/target_fsm.sv ====
// Target engine: address match, ACK, byte receive and byte transmit on the bus
`timescale 1ns/1ns

module target_fsm (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  standby_pkg::standby_cfg_t cfg_i,
  input  standby_pkg::bus_cond_t    cond_i,
  output logic                      sda_o,
  output logic                      rx_byte_valid_o,
  output logic [7:0]                rx_byte_o,
  output logic                      tx_byte_req_o,
  input  logic [7:0]                tx_byte_i,
  output logic                      xfer_end_o,
  output standby_pkg::target_evt_t  evt_o
);

  standby_pkg::target_state_e state_q;
  logic [7:0] rx_sr_q;
  logic [7:0] tx_sr_q;
  logic [3:0] bit_cnt_q;
  logic       rnw_q;
  logic       addressed_q;
  logic       load_tx_q;
  logic       addr_match;

  assign addr_match = (rx_sr_q[7:1] == cfg_i.static_addr) ||
                      (cfg_i.dyn_addr_valid && (rx_sr_q[7:1] == cfg_i.dyn_addr));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q         <= standby_pkg::IDLE;
      rx_sr_q         <= '0;
      tx_sr_q         <= '1;
      bit_cnt_q       <= '0;
      rnw_q           <= 1'b0;
      addressed_q     <= 1'b0;
      load_tx_q       <= 1'b0;
      sda_o           <= 1'b1;
      rx_byte_valid_o <= 1'b0;
      rx_byte_o       <= '0;
      tx_byte_req_o   <= 1'b0;
      xfer_end_o      <= 1'b0;
      evt_o           <= '0;
    end else begin
      rx_byte_valid_o <= 1'b0;
      tx_byte_req_o   <= 1'b0;
      xfer_end_o      <= 1'b0;
      evt_o           <= '0;
      // Byte answer arrives the cycle after the request
      load_tx_q <= tx_byte_req_o;
      if (load_tx_q) begin
        tx_sr_q <= tx_byte_i;
      end

      if (!cfg_i.enable) begin
        state_q     <= standby_pkg::IDLE;
        sda_o       <= 1'b1;
        addressed_q <= 1'b0;
      end else if (cond_i.stop) begin
        state_q <= standby_pkg::IDLE;
        sda_o   <= 1'b1;
        if (addressed_q) begin
          xfer_end_o         <= 1'b1;
          evt_o.cmd_complete <= 1'b1;
        end
        addressed_q <= 1'b0;
      end else if (cond_i.start) begin
        // Also taken on repeated START
        state_q   <= standby_pkg::ADDR;
        sda_o     <= 1'b1;
        bit_cnt_q <= '0;
      end else begin
        case (state_q)
          standby_pkg::ADDR, standby_pkg::RX_BYTE: begin
            if (cond_i.scl_rise && (bit_cnt_q != 4'd8)) begin
              rx_sr_q   <= {rx_sr_q[6:0], cond_i.sda};
              bit_cnt_q <= bit_cnt_q + 4'd1;
            end else if (cond_i.scl_fall && (bit_cnt_q == 4'd8)) begin
              if (state_q == standby_pkg::RX_BYTE) begin
                sda_o           <= 1'b0;
                rx_byte_valid_o <= 1'b1;
                rx_byte_o       <= rx_sr_q;
                state_q         <= standby_pkg::RX_ACK;
              end else if (addr_match) begin
                sda_o          <= 1'b0;
                rnw_q          <= rx_sr_q[0];
                addressed_q    <= 1'b1;
                evt_o.read_cmd <= rx_sr_q[0];
                tx_byte_req_o  <= rx_sr_q[0];
                state_q        <= standby_pkg::ADDR_ACK;
              end else begin
                state_q <= standby_pkg::IDLE;
              end
            end
          end
          standby_pkg::ADDR_ACK: begin
            if (cond_i.scl_fall) begin
              bit_cnt_q <= '0;
              if (rnw_q) begin
                sda_o   <= tx_sr_q[7];
                tx_sr_q <= {tx_sr_q[6:0], 1'b1};
                state_q <= standby_pkg::TX_BYTE;
              end else begin
                sda_o   <= 1'b1;
                state_q <= standby_pkg::RX_BYTE;
              end
            end
          end
          standby_pkg::RX_ACK: begin
            if (cond_i.scl_fall) begin
              sda_o     <= 1'b1;
              bit_cnt_q <= '0;
              state_q   <= standby_pkg::RX_BYTE;
            end
          end
          standby_pkg::TX_BYTE: begin
            if (cond_i.scl_rise) begin
              bit_cnt_q <= bit_cnt_q + 4'd1;
            end else if (cond_i.scl_fall && (bit_cnt_q == 4'd8)) begin
              sda_o   <= 1'b1;
              state_q <= standby_pkg::TX_ACK;
            end else if (cond_i.scl_fall) begin
              sda_o   <= tx_sr_q[7];
              tx_sr_q <= {tx_sr_q[6:0], 1'b1};
            end
          end
          standby_pkg::TX_ACK: begin
            if (cond_i.scl_rise && cond_i.sda) begin
              evt_o.nack <= 1'b1;
              state_q    <= standby_pkg::IDLE;
            end else if (cond_i.scl_rise) begin
              tx_byte_req_o <= 1'b1;
            end else if (cond_i.scl_fall) begin
              // Controller ACKed, start the next byte
              sda_o     <= tx_sr_q[7];
              tx_sr_q   <= {tx_sr_q[6:0], 1'b1};
              bit_cnt_q <= '0;
              state_q   <= standby_pkg::TX_BYTE;
            end
          end
          default: ;
        endcase
      end
    end
  end

  a_sda_drive_states: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !sda_o |-> state_q inside {standby_pkg::ADDR_ACK, standby_pkg::RX_ACK, standby_pkg::TX_BYTE}
  ) else $error("target_fsm: SDA pulled low outside an ACK or data phase");

endmodule

// ==== logic/byte_flow.sv ====
// Byte flow: packs RX bytes into queue words and splits TX queue words into bytes
`timescale 1ns/1ns
`include "standby_settings.svh"

module byte_flow (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    rx_byte_valid_i,
  input  logic [7:0]              rx_byte_i,
  input  logic                    xfer_end_i,
  input  logic                    tx_byte_req_i,
  output logic [7:0]              tx_byte_o,
  output logic                    rx_queue_wvalid_o,
  input  logic                    rx_queue_wready_i,
  output logic [`STBY_WORD_W-1:0] rx_queue_wdata_o,
  input  logic                    tx_queue_rvalid_i,
  output logic                    tx_queue_rready_o,
  input  logic [`STBY_WORD_W-1:0] tx_queue_rdata_i,
  output logic                    overflow_o
);

  localparam int unsigned bytes_per_word = `STBY_WORD_W / 8;
  localparam int unsigned idx_w = $clog2(bytes_per_word);

  logic [`STBY_WORD_W-1:0] rx_word_q;
  logic [`STBY_WORD_W-1:0] rx_word_next;
  logic [`STBY_WORD_W-1:0] tx_word_q;
  logic [idx_w-1:0]        rx_idx_q;
  logic [idx_w-1:0]        tx_idx_q;
  logic                    rx_push;
  logic                    rx_load;
  logic                    tx_fetch;

  always_comb begin
    rx_word_next = rx_word_q;
    rx_word_next[8*rx_idx_q +: 8] = rx_byte_i;
  end

  // Word complete, or a partial word flushed at STOP
  assign rx_push = (rx_byte_valid_i && (rx_idx_q == idx_w'(bytes_per_word - 1))) ||
                   (xfer_end_i && (rx_idx_q != '0));
  // Dropped while the held word is still waiting
  assign rx_load = rx_push && !(rx_queue_wvalid_o && !rx_queue_wready_i);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rx_idx_q          <= '0;
      rx_word_q         <= '0;
      rx_queue_wvalid_o <= 1'b0;
      overflow_o        <= 1'b0;
    end else begin
      overflow_o <= rx_push && !rx_load;
      if (rx_push) begin
        rx_idx_q  <= '0;
        rx_word_q <= '0;
      end else if (rx_byte_valid_i) begin
        rx_idx_q  <= rx_idx_q + 1'b1;
        rx_word_q <= rx_word_next;
      end
      if (rx_load) begin
        rx_queue_wvalid_o <= 1'b1;
      end else if (rx_queue_wready_i) begin
        rx_queue_wvalid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_load) begin
      rx_queue_wdata_o <= rx_byte_valid_i ? rx_word_next : rx_word_q;
    end
  end

  // New TX word pulled when the byte index is back at zero
  assign tx_fetch          = tx_byte_req_i && (tx_idx_q == '0);
  assign tx_queue_rready_o = tx_fetch;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_idx_q <= '0;
    end else if (xfer_end_i) begin
      tx_idx_q <= '0;
    end else if (tx_byte_req_i && !(tx_fetch && !tx_queue_rvalid_i)) begin
      tx_idx_q <= tx_idx_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tx_fetch && tx_queue_rvalid_i) begin
      tx_word_q <= tx_queue_rdata_i;
    end
    if (tx_fetch) begin
      // Empty queue reads as all ones on the bus
      tx_byte_o <= tx_queue_rvalid_i ? tx_queue_rdata_i[7:0] : 8'hFF;
    end else if (tx_byte_req_i) begin
      tx_byte_o <= tx_word_q[8*tx_idx_q +: 8];
    end
  end

  a_rx_word_held: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    rx_queue_wvalid_o && !rx_queue_wready_i |=> rx_queue_wvalid_o && $stable(rx_queue_wdata_o)
  ) else $error("byte_flow: RX word changed before it was accepted");

endmodule

// ==== logic/controller_standby_i3c.sv ====
// Standby I3C/I2C target front end: registers, bus monitor, timers, engine, byte flow
`timescale 1ns/1ns
`include "standby_settings.svh"

module controller_standby_i3c (
  input  logic                     clk_i,
  input  logic                     rst_n_i,

  input  logic                     reg_we_i,
  input  standby_pkg::reg_addr_e   reg_addr_i,
  input  logic [`STBY_WORD_W-1:0]  reg_wdata_i,
  output logic [`STBY_WORD_W-1:0]  reg_rdata_o,

  // Open-drain bus, SDA pull-down active low
  input  logic                     ctrl_scl_i,
  input  logic                     ctrl_sda_i,
  output logic                     ctrl_sda_o,

  output logic                     rx_queue_wvalid_o,
  input  logic                     rx_queue_wready_i,
  output logic [`STBY_WORD_W-1:0]  rx_queue_wdata_o,

  input  logic                     tx_queue_rvalid_i,
  output logic                     tx_queue_rready_o,
  input  logic [`STBY_WORD_W-1:0]  tx_queue_rdata_i,

  output standby_pkg::target_evt_t evt_o
);

  standby_pkg::standby_cfg_t cfg;
  standby_pkg::bus_cond_t    bus_cond;
  standby_pkg::bus_state_t   bus_state;
  standby_pkg::target_evt_t  fsm_evt;

  logic       rx_byte_valid;
  logic [7:0] rx_byte;
  logic       tx_byte_req;
  logic [7:0] tx_byte;
  logic       xfer_end;
  logic       rx_overflow;

  standby_regs xstandby_regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_we_i    (reg_we_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .bus_state_i (bus_state),
    .cfg_o       (cfg)
  );

  bus_monitor xbus_monitor (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .enable_i (cfg.enable),
    .scl_i    (ctrl_scl_i),
    .sda_i    (ctrl_sda_i),
    .cond_o   (bus_cond)
  );

  bus_timers xbus_timers (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .cfg_i   (cfg),
    .cond_i  (bus_cond),
    .state_o (bus_state)
  );

  target_fsm xtarget_fsm (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .cfg_i           (cfg),
    .cond_i          (bus_cond),
    .sda_o           (ctrl_sda_o),
    .rx_byte_valid_o (rx_byte_valid),
    .rx_byte_o       (rx_byte),
    .tx_byte_req_o   (tx_byte_req),
    .tx_byte_i       (tx_byte),
    .xfer_end_o      (xfer_end),
    .evt_o           (fsm_evt)
  );

  byte_flow xbyte_flow (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .rx_byte_valid_i   (rx_byte_valid),
    .rx_byte_i         (rx_byte),
    .xfer_end_i        (xfer_end),
    .tx_byte_req_i     (tx_byte_req),
    .tx_byte_o         (tx_byte),
    .rx_queue_wvalid_o (rx_queue_wvalid_o),
    .rx_queue_wready_i (rx_queue_wready_i),
    .rx_queue_wdata_o  (rx_queue_wdata_o),
    .tx_queue_rvalid_i (tx_queue_rvalid_i),
    .tx_queue_rready_o (tx_queue_rready_o),
    .tx_queue_rdata_i  (tx_queue_rdata_i),
    .overflow_o        (rx_overflow)
  );

  // Overflow comes from the RX packer, the rest from the engine
  always_comb begin
    evt_o             = fsm_evt;
    evt_o.rx_overflow = rx_overflow;
  end

endmodule

// ==== verification/tb_bus_tasks.svh ====
// Controller-side bus model: START, STOP, bit and byte transfers with a 40-clock SCL period

task automatic wait_clks(input int n);
  repeat (n) @(posedge clk_i);
endtask

// SCL high, SDA high on entry
task automatic bus_start();
  wait_clks(10);
  sda_drv <= 1'b0;
  wait_clks(10);
  ctrl_scl_i <= 1'b0;
  wait_clks(10);
endtask

// SCL low on entry; returns on the edge where SDA is released
task automatic bus_stop();
  sda_drv <= 1'b0;
  wait_clks(10);
  ctrl_scl_i <= 1'b1;
  wait_clks(10);
  sda_drv <= 1'b1;
endtask

task automatic write_bit(input logic b);
  sda_drv <= b;
  wait_clks(10);
  ctrl_scl_i <= 1'b1;
  wait_clks(20);
  ctrl_scl_i <= 1'b0;
  wait_clks(10);
endtask

task automatic read_bit(output logic b);
  sda_drv <= 1'b1;
  wait_clks(10);
  ctrl_scl_i <= 1'b1;
  wait_clks(10);
  // Middle of the high phase
  b = sda_bus;
  wait_clks(10);
  ctrl_scl_i <= 1'b0;
  wait_clks(10);
endtask

task automatic write_byte(input logic [7:0] data, output logic ack);
  logic bit_v;
  for (int i = 7; i >= 0; i--) begin
    write_bit(data[i]);
  end
  read_bit(bit_v);
  ack = !bit_v;
endtask

task automatic read_byte(output logic [7:0] data, input logic ack);
  logic bit_v;
  data = 8'h00;
  for (int i = 0; i < 8; i++) begin
    read_bit(bit_v);
    data = {data[6:0], bit_v};
  end
  write_bit(!ack);
endtask

// ==== verification/tb_controller_standby.sv ====
// Testbench for the standby target front end with bus transfers, queues, registers and timers
`timescale 1ns/1ns
`include "standby_settings.svh"

module tb_controller_standby;

  logic                     clk_i;
  logic                     rst_n_i;
  logic                     reg_we_i;
  standby_pkg::reg_addr_e   reg_addr_i;
  logic [31:0]              reg_wdata_i;
  logic [31:0]              reg_rdata_o;
  logic                     ctrl_scl_i;
  logic                     ctrl_sda_i;
  logic                     ctrl_sda_o;
  logic                     rx_queue_wvalid_o;
  logic                     rx_queue_wready_i;
  logic [31:0]              rx_queue_wdata_o;
  logic                     tx_queue_rvalid_i;
  logic                     tx_queue_rready_o;
  logic [31:0]              tx_queue_rdata_i;
  standby_pkg::target_evt_t evt_o;

  logic        sda_drv;
  logic        sda_bus;
  logic        val_chk;
  string       val_name;
  logic [31:0] val_got;
  logic [31:0] val_exp;
  logic        rd_chk;
  logic [31:0] rd_exp;
  logic        idle_chk;
  logic        no_ack_phase;
  logic        ovf_phase;
  logic        rx_hold;
  logic [31:0] wdata_prev;
  logic [31:0] exp_words [0:7];
  logic [3:0]  exp_n;
  logic [3:0]  rx_cnt;
  logic [31:0] tx_words [0:3];
  logic [2:0]  tx_n;
  logic [1:0]  tx_rd;
  logic [1:0]  tx_nxt;
  logic [31:0] rnd;
  integer      seed;
  int          n_cmd;
  int          n_nack;
  int          n_read;
  int          n_ovf;
  int          errors;
  int          checks;
  int          tests;
  logic        ack;
  logic [7:0]  data;
  logic [7:0]  exp_byte;

  // Open-drain wired AND
  assign sda_bus    = sda_drv & ctrl_sda_o;
  assign ctrl_sda_i = sda_bus;

  controller_standby_i3c UUT (.*);

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    rnd = $random(seed);
    rx_queue_wready_i <= rx_hold ? 1'b0 : rnd[0];
    wdata_prev <= rx_queue_wdata_o;
    if (rx_queue_wvalid_o && rx_queue_wready_i) rx_cnt <= rx_cnt + 4'd1;
    if (evt_o.cmd_complete) n_cmd <= n_cmd + 1;
    if (evt_o.nack) n_nack <= n_nack + 1;
    if (evt_o.read_cmd) n_read <= n_read + 1;
    if (evt_o.rx_overflow) n_ovf <= n_ovf + 1;
  end

  // TX queue model
  always @(posedge clk_i) begin
    tx_nxt = tx_rd;
    if (tx_queue_rready_o && tx_queue_rvalid_i) tx_nxt = tx_rd + 2'd1;
    tx_rd <= tx_nxt;
    tx_queue_rvalid_i <= ({1'b0, tx_nxt} < tx_n);
    tx_queue_rdata_i  <= tx_words[tx_nxt];
  end

  a_value: assert property (@(posedge clk_i) val_chk |-> val_got == val_exp)
    else begin
      $display("Fail %s got %h exp %h", val_name, $sampled(val_got), $sampled(val_exp));
      errors++;
    end

  a_reg: assert property (@(posedge clk_i) rd_chk |-> reg_rdata_o == rd_exp)
    else begin
      $display("Fail reg_rdata_o got %h exp %h", $sampled(reg_rdata_o), $sampled(rd_exp));
      errors++;
    end

  a_idle_outputs: assert property (@(posedge clk_i) idle_chk |->
    (!rx_queue_wvalid_o && !tx_queue_rready_o && evt_o == '0 && ctrl_sda_o))
    else begin
      $display("Outputs were not inactive after reset");
      errors++;
    end

  a_no_ack: assert property (@(posedge clk_i) no_ack_phase |-> ctrl_sda_o && !rx_queue_wvalid_o)
    else begin
      $display("Target answered a transfer to an unmatched address");
      errors++;
    end

  a_rx_word: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (rx_queue_wvalid_o && rx_queue_wready_i) |->
    (rx_cnt < exp_n) && (rx_queue_wdata_o == exp_words[rx_cnt[2:0]]))
    else begin
      $display("Fail rx_queue_wdata_o got %h exp %h", $sampled(rx_queue_wdata_o),
               $sampled(exp_words[rx_cnt[2:0]]));
      errors++;
    end

  a_held_word: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ovf_phase && rx_queue_wvalid_o && !rx_queue_wready_i) |=> $stable(rx_queue_wdata_o))
    else begin
      $display("Fail rx_queue_wdata_o got %h exp %h", $sampled(rx_queue_wdata_o),
               $sampled(wdata_prev));
      errors++;
    end

  `include "tb_bus_tasks.svh"

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    val_name <= name;
    val_got  <= got;
    val_exp  <= exp;
    val_chk  <= 1'b1;
    checks++;
    @(posedge clk_i);
    val_chk <= 1'b0;
    @(posedge clk_i);
  endtask

  task automatic check_reg(input standby_pkg::reg_addr_e addr, input logic [31:0] exp);
    reg_addr_i <= addr;
    rd_exp     <= exp;
    rd_chk     <= 1'b1;
    checks++;
    @(posedge clk_i);
    rd_chk <= 1'b0;
  endtask

  task automatic write_reg(input standby_pkg::reg_addr_e addr, input logic [31:0] wdata);
    reg_we_i    <= 1'b1;
    reg_addr_i  <= addr;
    reg_wdata_i <= wdata;
    @(posedge clk_i);
    reg_we_i <= 1'b0;
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("Test %0d %s finished, %0d errors so far", tests, name, errors);
  endtask

  task automatic timeout_fail(input string what);
    $display("Timed out waiting for %s", what);
    $display("Checks failed");
    $finish;
  endtask

  task automatic wait_rx_words(input logic [3:0] n);
    int t;
    t = 0;
    while (rx_cnt < n) begin
      @(posedge clk_i);
      t++;
      if (t > 5000) timeout_fail("RX queue words");
    end
  endtask

  initial begin
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    reg_we_i = 1'b0;
    reg_addr_i = standby_pkg::REG_CTRL;
    reg_wdata_i = '0;
    ctrl_scl_i = 1'b1;
    sda_drv = 1'b1;
    rx_queue_wready_i = 1'b0;
    tx_queue_rvalid_i = 1'b0;
    tx_queue_rdata_i = '0;
    val_chk = 1'b0;
    rd_chk = 1'b0;
    idle_chk = 1'b0;
    no_ack_phase = 1'b0;
    ovf_phase = 1'b0;
    rx_hold = 1'b0;
    exp_n = '0;
    rx_cnt = '0;
    tx_n = '0;
    tx_rd = '0;
    seed = 32'h74a4_3af0;
    for (int i = 0; i < 8; i++) exp_words[i] = '0;
    for (int i = 0; i < 4; i++) tx_words[i] = '0;
    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // Reset state and register access
    idle_chk <= 1'b1;
    checks++;
    @(posedge clk_i);
    idle_chk <= 1'b0;
    check_reg(standby_pkg::REG_STATUS, 32'h0);
    check_reg(standby_pkg::REG_CTRL, 32'h0);
    check_reg(standby_pkg::REG_ADDR,
              {16'h0, 1'b0, `STBY_DYN_ADDR_RST, 1'b0, `STBY_STATIC_ADDR_RST});
    check_reg(standby_pkg::REG_T_FREE, {12'h0, `STBY_T_FREE_RST});
    check_reg(standby_pkg::REG_T_IDLE, {12'h0, `STBY_T_IDLE_RST});
    check_reg(standby_pkg::REG_T_AVAIL, {12'h0, `STBY_T_AVAIL_RST});
    write_reg(standby_pkg::REG_CTRL, 32'd1);
    check_reg(standby_pkg::REG_CTRL, 32'd1);
    write_reg(standby_pkg::REG_T_AVAIL, 32'd200);
    check_reg(standby_pkg::REG_T_AVAIL, 32'd200);
    finish_test("reset and registers");

    // Five bytes to the static address
    exp_words[0] = 32'h4433_2211;
    exp_words[1] = 32'h0000_0055;
    exp_n = 4'd2;
    bus_start();
    write_byte({7'h22, 1'b0}, ack);
    check_val("address ack", 32'(ack), 32'd1);
    for (int i = 0; i < 5; i++) begin
      write_byte(8'(8'h11 * (i + 1)), ack);
      check_val("data ack", 32'(ack), 32'd1);
    end
    bus_stop();
    wait_clks(20);
    wait_rx_words(4'd2);
    check_val("cmd_complete count", 32'(n_cmd), 32'd1);
    finish_test("static address write");

    // Unmatched address and then the dynamic address
    no_ack_phase <= 1'b1;
    bus_start();
    write_byte({7'h33, 1'b0}, ack);
    check_val("unmatched address ack", 32'(ack), 32'd0);
    write_byte(8'h99, ack);
    check_val("unmatched data ack", 32'(ack), 32'd0);
    bus_stop();
    wait_clks(20);
    no_ack_phase <= 1'b0;
    write_reg(standby_pkg::REG_ADDR, 32'h0000_DA22);
    check_reg(standby_pkg::REG_ADDR, 32'h0000_DA22);
    exp_words[2] = 32'h0000_0077;
    exp_n = 4'd3;
    bus_start();
    write_byte({7'h5A, 1'b0}, ack);
    check_val("dynamic address ack", 32'(ack), 32'd1);
    write_byte(8'h77, ack);
    check_val("data ack", 32'(ack), 32'd1);
    bus_stop();
    wait_clks(20);
    wait_rx_words(4'd3);
    finish_test("address match");

    // Read one TX word and then an empty queue
    tx_words[0] = 32'h8421_c35a;
    tx_n <= 3'd1;
    wait_clks(4);
    bus_start();
    write_byte({7'h22, 1'b1}, ack);
    check_val("read address ack", 32'(ack), 32'd1);
    for (int i = 0; i < 5; i++) begin
      read_byte(data, i < 4);
      exp_byte = (i < 4) ? 8'(tx_words[0] >> (8 * i)) : 8'hFF;
      check_val("read byte", 32'(data), 32'(exp_byte));
    end
    bus_stop();
    wait_clks(20);
    check_val("nack count", 32'(n_nack), 32'd1);
    check_val("read_cmd count", 32'(n_read), 32'd1);
    check_val("cmd_complete count", 32'(n_cmd), 32'd3);
    finish_test("read transfer");

    // Bus levels after STOP
    write_reg(standby_pkg::REG_T_FREE, 32'd50);
    write_reg(standby_pkg::REG_T_IDLE, 32'd100);
    write_reg(standby_pkg::REG_T_AVAIL, 32'd150);
    bus_start();
    bus_stop();
    // Stop pulse trails the SDA release by 3 cycles
    repeat (53) @(posedge clk_i);
    check_reg(standby_pkg::REG_STATUS, 32'h0);
    check_reg(standby_pkg::REG_STATUS, 32'h4);
    repeat (48) @(posedge clk_i);
    check_reg(standby_pkg::REG_STATUS, 32'h4);
    check_reg(standby_pkg::REG_STATUS, 32'h6);
    repeat (48) @(posedge clk_i);
    check_reg(standby_pkg::REG_STATUS, 32'h6);
    check_reg(standby_pkg::REG_STATUS, 32'h7);
    bus_start();
    check_reg(standby_pkg::REG_STATUS, 32'h8);
    bus_stop();
    wait_clks(20);
    finish_test("bus timers");

    // Two words while the RX queue is stalled
    exp_words[3] = 32'hA3A2_A1A0;
    exp_n = 4'd4;
    rx_hold <= 1'b1;
    wait_clks(4);
    ovf_phase <= 1'b1;
    bus_start();
    write_byte({7'h22, 1'b0}, ack);
    check_val("address ack", 32'(ack), 32'd1);
    for (int i = 0; i < 8; i++) begin
      write_byte(8'hA0 + 8'(i), ack);
      check_val("data ack", 32'(ack), 32'd1);
    end
    bus_stop();
    wait_clks(20);
    check_val("rx_overflow count", 32'(n_ovf), 32'd1);
    check_val("accepted words", 32'(rx_cnt), 32'd3);
    ovf_phase <= 1'b0;
    rx_hold <= 1'b0;
    wait_rx_words(4'd4);
    finish_test("RX overflow");

    wait_clks(10);
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+logic
+incdir+verification
logic/standby_pkg.sv
logic/bus_monitor.sv
logic/bus_timers.sv
logic/standby_regs.sv
logic/target_fsm.sv
logic/byte_flow.sv
logic/controller_standby_i3c.sv
verification/tb_controller_standby.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert
TOP       = tb_controller_standby
FILELIST  = sim.f
PASS_MSG  = All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
